// ==== common/sram_pkg.sv ====
package sram_pkg;

	// One 32-bit access takes this many cycles, split evenly into two halves.
	localparam int SRAM_CYCLES = 6;

	// Counter width inside the SRAM block.
	localparam int SRAM_CNT_W = $clog2(SRAM_CYCLES);

	// Request queue depth, also the host's request credits after reset.
	localparam int REQ_DEPTH = 4;

	// Response queue depth and its occupancy width.
	localparam int RSP_DEPTH = 4;
	localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);

	// Response credits the host is assumed to grant out of reset.
	localparam int RSP_CREDITS = 2;
	localparam int RSP_CREDIT_W = 8;

	// External SRAM geometry, 256K x 16.
	localparam int SRAM_ADDR_W = 18;
	localparam int SRAM_DATA_W = 16;

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} mem_rsp_t;

	// All strobes are active low.
	typedef struct packed {
		logic [SRAM_ADDR_W-1:0] addr;
		logic [SRAM_DATA_W-1:0] dout;
		logic                   dout_en;
		logic                   ce_n;
		logic                   oe_n;
		logic                   we_n;
		logic                   lb_n;
		logic                   ub_n;
	} sram_pins_t;

endpackage

// ==== source/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  logic                         i_push,
	input  T                             i_data,
	input  logic                         i_pop,
	output T                             o_data,
	output logic                         o_empty,
	output logic [$clog2(DEPTH+1)-1:0]   o_count
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_pop;

	// Sender holds credits, so a push never meets a full buffer.
	assign do_pop  = i_pop && !o_empty;
	assign o_empty = (o_count == '0);

	// Head entry shows without waiting for a pop.
	assign o_data = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (i_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (i_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			// Simultaneous push and pop leave occupancy unchanged.
			if (i_push && !do_pop)
				o_count <= o_count + 1'b1;
			else if (!i_push && do_pop)
				o_count <= o_count - 1'b1;
		end
	end

endmodule

// ==== sram/sram_interface.sv ====
`timescale 1ns/1ps

module sram_interface import sram_pkg::*; (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_request,
	input  logic                   i_rw,
	input  logic [31:0]            i_address,
	input  logic [31:0]            i_wdata,
	input  logic [SRAM_DATA_W-1:0] i_sram_d,
	output logic [31:0]            o_rdata,
	output logic                   o_ready,
	output sram_pins_t             o_sram
);
	localparam int HALF = SRAM_CYCLES / 2;

	logic [SRAM_CNT_W-1:0] count;
	logic                  upper_half;
	logic                  is_write;
	logic                  is_read;

	assign is_write   = i_request && i_rw;
	assign is_read    = i_request && !i_rw;
	assign upper_half = (count >= SRAM_CNT_W'(HALF));

	// Ready during the last cycle of the window.
	assign o_ready = i_request && (count == SRAM_CNT_W'(SRAM_CYCLES - 1));

	// Pin outputs follow the counter directly.
	always_comb begin
		o_sram = '0;

		// Even halfword holds bits 15:0, odd holds bits 31:16.
		o_sram.addr = {i_address[18:2], upper_half};

		o_sram.ce_n = !i_request;
		o_sram.oe_n = !is_read;

		// Write pulse in the first cycle of each half.
		// The SRAM stores on the rising edge one cycle later.
		o_sram.we_n = 1'b1;
		if (is_write && (count == '0 || count == SRAM_CNT_W'(HALF)))
			o_sram.we_n = 1'b0;

		o_sram.dout_en = is_write;
		if (is_write)
			o_sram.dout = upper_half ? i_wdata[31:16] : i_wdata[15:0];

		// Full-word accesses only.
		o_sram.lb_n = 1'b0;
		o_sram.ub_n = 1'b0;
	end

	// Window counter, cleared by the idle cycle between accesses.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end else if (!i_request) begin
			count <= '0;
		end else if (count != SRAM_CNT_W'(SRAM_CYCLES - 1)) begin
			count <= count + 1'b1;
		end
	end

	// Sample each halfword through its half; the last sample of the half stands.
	always_ff @(posedge i_clock) begin
		if (is_read) begin
			if (upper_half)
				o_rdata[31:16] <= i_sram_d;
			else
				o_rdata[15:0] <= i_sram_d;
		end
	end

endmodule

// ==== source/mem_sequencer.sv ====
`timescale 1ns/1ps

module mem_sequencer import sram_pkg::*; (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_req_empty,
	input  mem_req_t             i_req_head,
	input  logic [RSP_CNT_W-1:0] i_rsp_count,
	input  logic                 i_rsp_empty,
	input  logic                 i_rsp_credit,
	input  logic                 i_access_ready,
	input  logic [31:0]          i_access_rdata,
	output logic                 o_req_pop,
	output logic                 o_req_credit,
	output logic                 o_access_req,
	output logic                 o_access_rw,
	output logic [31:0]          o_access_addr,
	output logic [31:0]          o_access_wdata,
	output logic                 o_rsp_push,
	output mem_rsp_t             o_rsp_data,
	output logic                 o_rsp_pop,
	output logic                 o_rsp_valid
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_FINISH
	} state_t;

	state_t                  state;
	mem_req_t                req_q;
	logic [RSP_CNT_W:0]      slots_used;
	logic [RSP_CREDIT_W-1:0] rsp_credits;

	// A read being pushed this cycle already holds its slot.
	assign slots_used = {1'b0, i_rsp_count} + {{RSP_CNT_W{1'b0}}, o_rsp_push};

	// Next request may be taken while idle or in the finish cycle.
	assign o_req_pop = (state == ST_IDLE || state == ST_FINISH) && !i_req_empty &&
		(i_req_head.write || slots_used < (RSP_CNT_W+1)'(RSP_DEPTH));
	assign o_req_credit = o_req_pop;

	assign o_access_req   = (state == ST_ACCESS);
	assign o_access_rw    = req_q.write;
	assign o_access_addr  = req_q.addr;
	assign o_access_wdata = req_q.wdata;

	assign o_rsp_push       = (state == ST_FINISH) && !req_q.write;
	assign o_rsp_data.rdata = i_access_rdata;

	// One response per host credit.
	assign o_rsp_valid = (rsp_credits != '0) && !i_rsp_empty;
	assign o_rsp_pop   = o_rsp_valid;

	always_ff @(posedge i_clock) begin
		if (o_req_pop)
			req_q <= i_req_head;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (o_req_pop) state <= ST_ACCESS;
				ST_ACCESS: if (i_access_ready) state <= ST_FINISH;
				ST_FINISH: state <= o_req_pop ? ST_ACCESS : ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rsp_credits <= RSP_CREDIT_W'(RSP_CREDITS);
		end else if (i_rsp_credit && !o_rsp_valid) begin
			rsp_credits <= rsp_credits + 1'b1;
		end else if (!i_rsp_credit && o_rsp_valid) begin
			rsp_credits <= rsp_credits - 1'b1;
		end
	end

endmodule

// ==== source/sram_subsystem.sv ====
`timescale 1ns/1ps

module sram_subsystem import sram_pkg::*; (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_req_valid,
	input  mem_req_t               i_req,
	input  logic                   i_rsp_credit,
	input  logic [SRAM_DATA_W-1:0] i_sram_d,
	output logic                   o_req_credit,
	output logic                   o_rsp_valid,
	output mem_rsp_t               o_rsp,
	output sram_pins_t             o_sram
);
	mem_req_t             req_head;
	logic                 req_empty;
	logic                 req_pop;
	mem_rsp_t             rsp_data;
	logic                 rsp_push;
	logic                 rsp_pop;
	logic                 rsp_empty;
	logic [RSP_CNT_W-1:0] rsp_count;
	logic                 access_req;
	logic                 access_rw;
	logic [31:0]          access_addr;
	logic [31:0]          access_wdata;
	logic                 access_ready;
	logic [31:0]          access_rdata;

	// Host credits guarantee space, so every valid cycle is a push.
	credit_fifo #(.T(mem_req_t), .DEPTH(REQ_DEPTH)) u_req_fifo (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(i_req_valid), .i_data(i_req), .i_pop(req_pop),
		.o_data(req_head), .o_empty(req_empty), .o_count()
	);

	credit_fifo #(.T(mem_rsp_t), .DEPTH(RSP_DEPTH)) u_rsp_fifo (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(rsp_push), .i_data(rsp_data), .i_pop(rsp_pop),
		.o_data(o_rsp), .o_empty(rsp_empty), .o_count(rsp_count)
	);

	mem_sequencer u_sequencer (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_req_empty(req_empty), .i_req_head(req_head),
		.i_rsp_count(rsp_count), .i_rsp_empty(rsp_empty), .i_rsp_credit(i_rsp_credit),
		.i_access_ready(access_ready), .i_access_rdata(access_rdata),
		.o_req_pop(req_pop), .o_req_credit(o_req_credit),
		.o_access_req(access_req), .o_access_rw(access_rw),
		.o_access_addr(access_addr), .o_access_wdata(access_wdata),
		.o_rsp_push(rsp_push), .o_rsp_data(rsp_data),
		.o_rsp_pop(rsp_pop), .o_rsp_valid(o_rsp_valid)
	);

	sram_interface u_sram (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(access_req), .i_rw(access_rw),
		.i_address(access_addr), .i_wdata(access_wdata), .i_sram_d(i_sram_d),
		.o_rdata(access_rdata), .o_ready(access_ready), .o_sram(o_sram)
	);

endmodule

// ==== test/sram_model.sv ====
`timescale 1ns/1ps

module sram_model import sram_pkg::*; (
	input  sram_pins_t             i_sram,
	output logic [SRAM_DATA_W-1:0] o_data
);
	localparam int WORDS = 1 << SRAM_ADDR_W;

	logic [SRAM_DATA_W-1:0] mem [WORDS];
	logic [SRAM_DATA_W-1:0] bus;
	logic                   we_n;
	logic                   read_en;

	assign we_n    = i_sram.we_n;
	assign read_en = !i_sram.ce_n && !i_sram.oe_n;

	// Shared data pins. The bridge drives them on writes, the array on reads.
	// Undriven pins read as zero.
	assign bus    = i_sram.dout_en ? i_sram.dout : (read_en ? mem[i_sram.addr] : '0);
	assign o_data = bus;

	// Power-up contents depend on every address bit.
	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = 16'(i) ^ 16'(i >> 16) ^ 16'h5a5a;
	end

	// The array latches the pins on the rising edge of write enable.
	always @(posedge we_n) begin
		if (!i_sram.ce_n && i_sram.dout_en)
			mem[i_sram.addr] = bus;
	end

endmodule

// ==== test/tb_sram_subsystem.sv ====
`timescale 1ns/1ps

module tb_sram_subsystem import sram_pkg::*; ();
	localparam int NUM_WRITES   = 12;
	localparam int NUM_ALIAS    = 4;
	localparam int NUM_BP_READS = 8;
	localparam int NUM_TXNS     = 2 * NUM_WRITES + 2 * NUM_ALIAS + NUM_BP_READS;
	localparam int BP_WAIT      = 150;
	localparam int WATCHDOG_CYCLES = NUM_TXNS * (SRAM_CYCLES + 1) * 4 + 500;

	logic                   clock = 1'b0;
	logic                   reset;
	logic                   req_valid;
	mem_req_t               req;
	logic                   rsp_credit;
	logic [SRAM_DATA_W-1:0] sram_d;
	logic                   req_credit;
	logic                   rsp_valid;
	mem_rsp_t               rsp;
	sram_pins_t             sram_pins;

	logic [31:0] seed;
	logic [31:0] ref_mem [logic [16:0]];
	logic [31:0] exp_q [$];
	logic [31:0] addrs [NUM_WRITES];
	logic        grant_enable;
	int          sent;
	int          returned;
	int          rsp_seen;
	int          granted;
	int          main_errors;
	int          rsp_errors;

	sram_subsystem u_dut (
		.i_clock(clock), .i_reset(reset), .i_req_valid(req_valid), .i_req(req),
		.i_rsp_credit(rsp_credit), .i_sram_d(sram_d),
		.o_req_credit(req_credit), .o_rsp_valid(rsp_valid), .o_rsp(rsp), .o_sram(sram_pins)
	);

	sram_model u_model (.i_sram(sram_pins), .o_data(sram_d));

	always #4 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Word store indexed by the halfword pair, so bits 1:0 and 31:19 alias.
	function automatic logic [31:0] ref_access(input logic write, input logic [31:0] addr,
			input logic [31:0] data);
		logic [16:0] key;
		key = addr[18:2];
		if (write)
			ref_mem[key] = data;
		return ref_mem[key];
	endfunction

	task automatic check_value(inout int count, input string name,
			input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			count++;
			$display("FAIL %0t %s expected %08h actual %08h", $time, name, expected, actual);
		end
	endtask

	// Sends only while a request credit is held.
	task automatic send_request(input logic write, input logic [31:0] addr,
			input logic [31:0] data);
		logic [31:0] expected;
		@(posedge clock);
		req_valid <= 1'b0;
		while (sent - returned >= REQ_DEPTH)
			@(posedge clock);
		expected = ref_access(write, addr, data);
		req_valid <= 1'b1;
		req <= '{write: write, addr: addr, wdata: data};
		sent++;
		if (!write)
			exp_q.push_back(expected);
	endtask

	task automatic end_burst();
		@(posedge clock);
		req_valid <= 1'b0;
	endtask

	// All credits home and all reads answered, then let the last access finish.
	task automatic wait_idle();
		end_burst();
		while (returned < sent || rsp_seen < exp_q.size())
			@(negedge clock);
		repeat (SRAM_CYCLES + 2) @(posedge clock);
	endtask

	// Response and credit monitor, sampled on the falling edge.
	initial begin
		returned = 0;
		rsp_seen = 0;
		rsp_errors = 0;
		forever begin
			@(negedge clock);
			if (!reset) begin
				if (req_credit)
					returned++;
				if (rsp_valid) begin
					if (rsp_seen >= exp_q.size()) begin
						rsp_errors++;
						$display("Response at %0t with no read outstanding", $time);
					end else begin
						check_value(rsp_errors, "o_rsp.rdata", exp_q[rsp_seen], rsp.rdata);
					end
					rsp_seen++;
				end
				if (returned > sent) begin
					rsp_errors++;
					$display("Request credit returned with none outstanding at %0t, %0d sent and %0d returned",
						$time, sent, returned);
				end
			end
		end
	end

	// Host returns one response credit per response taken, unless held.
	initial begin
		rsp_credit = 1'b0;
		granted = 0;
		forever begin
			@(posedge clock);
			if (grant_enable && rsp_seen > granted) begin
				rsp_credit <= 1'b1;
				granted++;
			end else begin
				rsp_credit <= 1'b0;
			end
		end
	end

	initial begin
		repeat (16 + WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout after %0d cycles, the bridge stopped making progress",
			16 + WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] word;
		logic [31:0] addr;
		int          base;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		seed = 32'd57;
		sent = 0;
		grant_enable = 1'b1;
		main_errors = 0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		check_value(main_errors, "o_rsp_valid", 32'd0, 32'(rsp_valid));
		check_value(main_errors, "o_req_credit", 32'd0, 32'(req_credit));
		check_value(main_errors, "o_sram.we_n", 32'd1, 32'(sram_pins.we_n));
		check_value(main_errors, "o_sram.oe_n", 32'd1, 32'(sram_pins.oe_n));
		check_value(main_errors, "o_sram.lb_n", 32'd0, 32'(sram_pins.lb_n));
		check_value(main_errors, "o_sram.ub_n", 32'd0, 32'(sram_pins.ub_n));

		// Write burst alone, no response expected.
		for (int i = 0; i < NUM_WRITES; i++) begin
			addrs[i] = lcg_next();
			send_request(1'b1, addrs[i], lcg_next());
		end
		wait_idle();
		check_value(main_errors, "o_rsp_valid count", 32'd0, rsp_seen);

		// Low half at the even halfword, high half at the odd one.
		for (int i = 0; i < NUM_WRITES; i++) begin
			word = ref_mem[addrs[i][18:2]];
			check_value(main_errors, "sram even halfword", {16'h0, word[15:0]},
				{16'h0, u_model.mem[{addrs[i][18:2], 1'b0}]});
			check_value(main_errors, "sram odd halfword", {16'h0, word[31:16]},
				{16'h0, u_model.mem[{addrs[i][18:2], 1'b1}]});
		end

		for (int i = 0; i < NUM_WRITES; i++)
			send_request(1'b0, addrs[i], 32'h0);
		wait_idle();

		// Read back through an alias of the written address.
		for (int i = 0; i < NUM_ALIAS; i++) begin
			addr = lcg_next();
			send_request(1'b1, addr, lcg_next());
			send_request(1'b0, addr ^ (lcg_next() & 32'hfff8_0003), 32'h0);
		end
		wait_idle();

		// Response credits held, so reads back up into the request queue.
		base = rsp_seen;
		@(negedge clock);
		grant_enable = 1'b0;
		fork
			begin
				for (int i = 0; i < NUM_BP_READS; i++)
					send_request(1'b0, addrs[i], 32'h0);
				end_burst();
			end
			begin
				repeat (BP_WAIT) @(posedge clock);
				check_value(main_errors, "o_rsp_valid count held", RSP_CREDITS, rsp_seen - base);
				@(negedge clock);
				grant_enable = 1'b1;
			end
		join
		wait_idle();
		check_value(main_errors, "o_rsp_valid count released", NUM_BP_READS, rsp_seen - base);
		check_value(main_errors, "o_req_credit pulses", sent, returned);

		$display("Errors: %0d host side, %0d response side, %0d responses",
			main_errors, rsp_errors, rsp_seen);
		if (main_errors + rsp_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
common/sram_pkg.sv
source/credit_fifo.sv
sram/sram_interface.sv
source/mem_sequencer.sv
source/sram_subsystem.sv
test/sram_model.sv
test/tb_sram_subsystem.sv

// ==== Makefile ====
TOP = tb_sram_subsystem

all: run

build:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
